/* pin_array.f */
+incdir+include
rtl/pin_array_pkg.sv
rtl/time_base.sv
rtl/pin_sequencer.sv
rtl/pin_controller.sv
rtl/pin_array.sv
sim/tb_clock_gen.sv
sim/pin_array_asserts.sv
sim/pin_array_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Iinclude
TOP       := pin_array_tb
RTL_TOP   := pin_array
FILELIST  := pin_array.f
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -Iinclude --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/pin_array_tb.sv */
`timescale 1ns/10ps
`include "pin_array_consts.svh"

module pin_array_tb;
  import pin_array_pkg::*;

  typedef enum {op_wr, op_rd, op_rd_lt, op_rd_same, op_rd_more, op_rd_near,
                op_smp, op_pin, op_nco, op_wait} op_t;

  typedef struct {
    string       name;
    op_t         op;
    int          ch;
    int          off;
    data_t       data;
    int          cycles;
    logic [31:0] exp;
  } row_t;

  logic clk;
  logic reset;
  bus_req_t bus_req;
  data_t rd_data;
  logic sample_req;
  chan_t sample_chan;
  sample_word_t sample_data;
  logic sample_valid;
  logic [`PA_NUM_CHANNELS-1:0] pin_in;
  logic [`PA_NUM_CHANNELS-1:0] pin_out;
  logic [`PA_NUM_CHANNELS-1:0] pin_oe;

  row_t rows[$];
  int errors = 0;
  int wd_cycles = 0;
  logic [31:0] seed = 32'h1f0c;
  data_t last_rd;

  tb_clock_gen tb_clock_gen_i (.clk(clk), .reset(reset));

  pin_array pin_array_i (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // True when act is no more than one away from exp.
  function automatic bit within_one(input logic [31:0] act, input logic [31:0] exp);
    return (act + 1 >= exp) && (act <= exp + 1);
  endfunction

  task automatic add_row(input string name, input op_t op, input int ch, input int off,
                         input data_t data, input int cycles, input logic [31:0] exp);
    row_t r;
    r = '{name, op, ch, off, data, cycles, exp};
    rows.push_back(r);
  endtask

  // Inputs change 10 ns after the rising edge.
  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic access(input int ch, input int off, input logic wr, input data_t d);
    bus_req = '{valid: 1'b1, write: wr, addr: {ch[7:0], off[7:0]}, wdata: d};
    step();
    bus_req = '0;
  endtask

  task automatic check(input string name, input logic ok, input logic [31:0] exp,
                       input logic [31:0] act);
    assert (ok) else begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic run_row(input row_t r);
    logic [7:0] win;
    int ones;
    data_t prev;
    sample_word_t exp_word;
    sample_word_t act_word;
    case (r.op)
      op_wr: access(r.ch, r.off, 1'b1, r.data);
      op_wait: repeat (r.cycles) step();
      op_pin: check(r.name, {pin_oe[r.ch], pin_out[r.ch]} == r.exp[1:0], r.exp,
                    {pin_oe[r.ch], pin_out[r.ch]});
      op_nco: begin
        ones = 0;
        for (int i = 0; i < 8; i++) begin
          step();
          win[i] = pin_out[r.ch];
          ones += win[i];
        end
        check(r.name, ones == r.exp, r.exp, ones);
        // Period of four cycles, so every bit is the inverse of the one two back.
        for (int i = 0; i < 6; i++) begin
          assert (win[i+2] != win[i]) else begin
            errors++;
            $display("%s: oscillator output is not in runs of two", r.name);
          end
        end
      end
      op_smp: begin
        sample_req = 1'b1;
        sample_chan = chan_t'(r.ch);
        step();
        sample_req = 1'b0;
        act_word = sample_data;
        if (r.ch < `PA_NUM_CHANNELS) begin
          // The count has a one-off bound, the other fields are exact.
          check(r.name, within_one(act_word.cnt, r.data), r.data, act_word.cnt);
          act_word.cnt = '0;
          exp_word = '{rsvd: 1'b0, cnt: '0, tag: 12'hABC, ones: 3'b111,
                       smp: r.exp[0]};
        end else begin
          exp_word = '0;
        end
        check(r.name, sample_valid == (r.ch < `PA_NUM_CHANNELS),
              r.ch < `PA_NUM_CHANNELS, sample_valid);
        check(r.name, act_word == exp_word, exp_word, act_word);
      end
      default: begin
        prev = last_rd;
        access(r.ch, r.off, 1'b0, '0);
        last_rd = rd_data;
        case (r.op)
          op_rd: check(r.name, rd_data == r.exp[15:0], r.exp, rd_data);
          op_rd_lt: check(r.name, rd_data < r.exp[15:0], r.exp, rd_data);
          op_rd_same: check(r.name, rd_data == prev, prev, rd_data);
          op_rd_more: check(r.name, rd_data > prev, prev, rd_data);
          default: check(r.name, within_one(rd_data, r.exp), r.exp, rd_data);
        endcase
      end
    endcase
  endtask

  task automatic build_table();
    int offs[7] = '{2, 3, 6, 11, 12, 13, 14};
    data_t vals[2][7];
    int chs[2] = '{0, 3};
    for (int c = 0; c < 2; c++) begin
      for (int k = 0; k < 7; k++) begin
        seed = xorshift32(seed);
        vals[c][k] = seed[15:0];
        add_row("reg_write", op_wr, chs[c], offs[k], vals[c][k], 0, 0);
        add_row("reg_readback", op_rd, chs[c], offs[k], 0, 0, vals[c][k]);
      end
      add_row("last_data", op_rd, chs[c], `PA_REG_LAST_DATA, 0, 0, vals[c][6]);
      add_row("status_idle", op_rd, chs[c], `PA_REG_STATUS, 0, 0, chs[c]);
    end
    for (int k = 0; k < 7; k++) begin
      add_row("channel_isolation", op_rd, 0, offs[k], 0, 0, vals[0][k]);
    end
    // Timebase freeze and run.
    add_row("time_clear", op_wr, 0, 0, `PA_GCMD_CLEAR_TIME, 0, 0);
    add_row("time_freeze", op_wr, 0, 0, `PA_GCMD_FREEZE, 0, 0);
    add_row("time_frozen_low", op_rd_lt, 0, 0, 0, 0, 10);
    add_row("time_wait", op_wait, 0, 0, 0, 5, 0);
    add_row("time_frozen_a", op_rd_same, 0, 0, 0, 0, 0);
    add_row("time_wait", op_wait, 0, 0, 0, 5, 0);
    add_row("time_frozen_b", op_rd_same, 0, 0, 0, 0, 0);
    add_row("time_run", op_wr, 0, 0, `PA_GCMD_RUN, 0, 0);
    add_row("time_wait", op_wait, 0, 0, 0, 5, 0);
    add_row("time_counts_up", op_rd_more, 0, 0, 0, 0, 0);
    // Constant level on channel 1 from 200 to 240.
    add_row("const_clear", op_wr, 0, 0, `PA_GCMD_CLEAR_TIME, 0, 0);
    add_row("const_start_l", op_wr, 1, `PA_REG_START_L, 200, 0, 0);
    add_row("const_start_h", op_wr, 1, `PA_REG_START_H, 0, 0, 0);
    add_row("const_end_l", op_wr, 1, `PA_REG_END_L, 240, 0, 0);
    add_row("const_end_h", op_wr, 1, `PA_REG_END_H, 0, 0, 0);
    add_row("const_cmd", op_wr, 1, `PA_REG_LOCAL_CMD, `PA_CMD_CONST, 0, 0);
    add_row("const_time_early", op_rd_lt, 0, 0, 0, 0, 200);
    add_row("const_pin_early", op_pin, 1, 0, 0, 0, 0);
    add_row("const_wait", op_wait, 0, 0, 0, 100, 0);
    add_row("const_time_before", op_rd_lt, 0, 0, 0, 0, 200);
    add_row("const_pin_before", op_pin, 1, 0, 0, 0, 0);
    add_row("const_wait", op_wait, 0, 0, 0, 110, 0);
    add_row("const_pin_active", op_pin, 1, 0, 0, 0, 3);
    add_row("const_wait", op_wait, 0, 0, 0, 40, 0);
    add_row("const_pin_ended", op_pin, 1, 0, 0, 0, 0);
    // Oscillator on channel 2 at a quarter of the clock.
    add_row("nco_low", op_wr, 2, `PA_REG_NCO_LOW, 0, 0, 0);
    add_row("nco_high", op_wr, 2, `PA_REG_NCO_HIGH, 16'h4000, 0, 0);
    add_row("nco_start_l", op_wr, 2, `PA_REG_START_L, 0, 0, 0);
    add_row("nco_start_h", op_wr, 2, `PA_REG_START_H, 0, 0, 0);
    add_row("nco_end_l", op_wr, 2, `PA_REG_END_L, 16'hffff, 0, 0);
    add_row("nco_end_h", op_wr, 2, `PA_REG_END_H, 16'hffff, 0, 0);
    add_row("nco_cmd", op_wr, 2, `PA_REG_LOCAL_CMD, `PA_CMD_START_OUTPUT, 0, 0);
    add_row("nco_wait", op_wait, 0, 0, 0, 5, 0);
    add_row("nco_window", op_nco, 2, 0, 0, 0, 4);
    add_row("nco_stop", op_wr, 2, `PA_REG_LOCAL_CMD, `PA_CMD_STOP, 0, 0);
    add_row("nco_wait", op_wait, 0, 0, 0, 3, 0);
    add_row("nco_pin_off", op_pin, 2, 0, 0, 0, 0);
    // Sampling on channel 3 every 4 cycles, ten samples.
    add_row("smp_rate", op_wr, 3, `PA_REG_SAMPLE_RATE, 4, 0, 0);
    add_row("smp_start_l", op_wr, 3, `PA_REG_START_L, 0, 0, 0);
    add_row("smp_start_h", op_wr, 3, `PA_REG_START_H, 0, 0, 0);
    add_row("smp_cmd", op_wr, 3, `PA_REG_LOCAL_CMD, `PA_CMD_INPUT_STREAM, 0, 0);
    add_row("smp_wait", op_wait, 0, 0, 0, 40, 0);
    add_row("smp_stop", op_wr, 3, `PA_REG_LOCAL_CMD, `PA_CMD_STOP, 0, 0);
    add_row("smp_bit", op_rd, 3, `PA_REG_SAMPLE_REG, 0, 0, 1);
    add_row("smp_count", op_rd_near, 3, `PA_REG_SAMPLE_CNT, 0, 0, 10);
    add_row("smp_readout", op_smp, 3, 0, 10, 0, 1);
    add_row("smp_no_channel", op_smp, 7, 0, 0, 0, 0);
  endtask

  initial begin
    bus_req = '0;
    sample_req = 1'b0;
    sample_chan = '0;
    pin_in = 4'b1000;
    last_rd = '0;
    build_table();
    foreach (rows[i]) wd_cycles += rows[i].cycles + 12;
    wd_cycles += 100;
    @(negedge reset);
    step();
    foreach (rows[i]) run_row(rows[i]);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (wd_cycles > 0);
    #(wd_cycles * 100);
    $display("Timeout: the tests did not finish in the expected time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* sim/pin_array_asserts.sv */
`timescale 1ns/10ps

module pin_array_asserts (
  input logic                      clk,
  input logic                      reset,
  input pin_array_pkg::seq_state_t state,
  input logic                      pin_oe,
  input logic                      cmd_clear
);
  import pin_array_pkg::*;

  // Enable lags the state by one cycle.
  oe_after_idle: assert property (@(posedge clk) disable iff (reset)
    ($past(state) == idle) |-> !pin_oe)
    else $error("pin_oe high after an idle cycle");

  state_legal: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(state) && (state inside {idle, run_nco, run_const, stream_in}))
    else $error("sequencer state is not a legal value");

  clear_pulse: assert property (@(posedge clk) disable iff (reset)
    cmd_clear |=> !cmd_clear)
    else $error("cmd_clear held for more than one cycle");

endmodule

bind pin_sequencer pin_array_asserts asserts_i (.*);

/* sim/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  // 100 ns period.
  initial clk = 1'b0;
  always #50 clk = ~clk;

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #10 reset = 1'b0;
  end

endmodule

/* rtl/pin_array.sv */
`timescale 1ns/10ps
`include "pin_array_consts.svh"

module pin_array (
  input  logic                         clk,
  input  logic                         reset,
  input  pin_array_pkg::bus_req_t      bus_req,
  output pin_array_pkg::data_t         rd_data,
  input  logic                         sample_req,
  input  pin_array_pkg::chan_t         sample_chan,
  output pin_array_pkg::sample_word_t  sample_data,
  output logic                         sample_valid,
  input  logic [`PA_NUM_CHANNELS-1:0]  pin_in,
  output logic [`PA_NUM_CHANNELS-1:0]  pin_out,
  output logic [`PA_NUM_CHANNELS-1:0]  pin_oe
);
  import pin_array_pkg::*;

  time_t        time_now;
  data_t        ctl_rd_data [`PA_NUM_CHANNELS];
  sample_word_t ctl_sample  [`PA_NUM_CHANNELS];
  sample_word_t sample_sel;
  logic         sample_hit;

  time_base time_base_i (
    .clk      (clk),
    .reset    (reset),
    .bus_req  (bus_req),
    .time_now (time_now)
  );

  for (genvar ch = 0; ch < `PA_NUM_CHANNELS; ch++) begin : g_ch
    pin_controller #(
      .CHANNEL (ch)
    ) pin_controller_i (
      .clk         (clk),
      .reset       (reset),
      .bus_req     (bus_req),
      .time_now    (time_now),
      .pin_in      (pin_in[ch]),
      .rd_data     (ctl_rd_data[ch]),
      .sample_word (ctl_sample[ch]),
      .pin_out     (pin_out[ch]),
      .pin_oe      (pin_oe[ch])
    );
  end

  // Only the addressed controller answers, the rest return zero.
  always_comb begin
    rd_data = '0;
    for (int ch = 0; ch < `PA_NUM_CHANNELS; ch++) begin
      rd_data = rd_data | ctl_rd_data[ch];
    end
  end

  always_comb begin
    sample_sel = '0;
    sample_hit = 1'b0;
    for (int ch = 0; ch < `PA_NUM_CHANNELS; ch++) begin
      if (sample_chan == chan_t'(ch)) begin
        sample_sel = ctl_sample[ch];
        sample_hit = 1'b1;
      end
    end
  end

  // Unknown channels get valid low and an all-zero word.
  always_ff @(posedge clk) begin
    if (reset) begin
      sample_valid <= 1'b0;
      sample_data  <= '0;
    end else begin
      sample_valid <= sample_req && sample_hit;
      sample_data  <= (sample_req && sample_hit) ? sample_sel : '0;
    end
  end

endmodule

/* rtl/pin_controller.sv */
`timescale 1ns/10ps
`include "pin_array_consts.svh"

module pin_controller #(
  parameter int CHANNEL = 0
) (
  input  logic                        clk,
  input  logic                        reset,
  input  pin_array_pkg::bus_req_t     bus_req,
  input  pin_array_pkg::time_t        time_now,
  input  logic                        pin_in,
  output pin_array_pkg::data_t        rd_data,
  output pin_array_pkg::sample_word_t sample_word,
  output logic                        pin_out,
  output logic                        pin_oe
);
  import pin_array_pkg::*;

  localparam chan_t CH_ID = chan_t'(CHANNEL);

  logic       chan_hit;
  logic       reg_wr;
  logic       reg_rd;
  logic [7:0] reg_off;
  phase_t     nco_incr;
  data_t      command;
  rate_t      sample_rate;
  time_t      start_time;
  time_t      end_time;
  data_t      last_data;
  logic       cmd_clear;
  seq_state_t state;
  logic       sample_bit;
  scnt_t      sample_cnt;

  assign chan_hit = bus_req.valid && (bus_req.addr[15:8] == CH_ID);
  assign reg_wr   = chan_hit && bus_req.write;
  assign reg_rd   = chan_hit && !bus_req.write;
  assign reg_off  = bus_req.addr[7:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      nco_incr    <= '0;
      command     <= '0;
      sample_rate <= '0;
      start_time  <= '0;
      end_time    <= '0;
      last_data   <= '0;
    end else begin
      if (reg_wr) begin
        last_data <= bus_req.wdata;
        case (reg_off)
          `PA_REG_NCO_LOW:     nco_incr[15:0]    <= bus_req.wdata;
          `PA_REG_NCO_HIGH:    nco_incr[31:16]   <= bus_req.wdata;
          `PA_REG_SAMPLE_RATE: sample_rate       <= bus_req.wdata;
          `PA_REG_START_L:     start_time[15:0]  <= bus_req.wdata;
          `PA_REG_START_H:     start_time[31:16] <= bus_req.wdata;
          `PA_REG_END_L:       end_time[15:0]    <= bus_req.wdata;
          `PA_REG_END_H:       end_time[31:16]   <= bus_req.wdata;
          default: ;
        endcase
      end
      // A fresh command write takes precedence over the clear.
      if (reg_wr && (reg_off == `PA_REG_LOCAL_CMD)) begin
        command <= bus_req.wdata;
      end else if (cmd_clear) begin
        command <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data <= '0;
    end else if (reg_rd) begin
      case (reg_off)
        // Offset 0 reads back the low half of the timebase.
        `PA_REG_GLOBAL_CMD:  rd_data <= time_now[15:0];
        `PA_REG_NCO_LOW:     rd_data <= nco_incr[15:0];
        `PA_REG_NCO_HIGH:    rd_data <= nco_incr[31:16];
        `PA_REG_LOCAL_CMD:   rd_data <= command;
        `PA_REG_SAMPLE_RATE: rd_data <= sample_rate;
        `PA_REG_SAMPLE_REG:  rd_data <= {15'd0, sample_bit};
        `PA_REG_SAMPLE_CNT:  rd_data <= {1'b0, sample_cnt};
        `PA_REG_STATUS:      rd_data <= {6'd0, state, CH_ID};
        `PA_REG_LAST_DATA:   rd_data <= last_data;
        `PA_REG_START_L:     rd_data <= start_time[15:0];
        `PA_REG_START_H:     rd_data <= start_time[31:16];
        `PA_REG_END_L:       rd_data <= end_time[15:0];
        `PA_REG_END_H:       rd_data <= end_time[31:16];
        default:             rd_data <= '0;
      endcase
    end else begin
      rd_data <= '0;
    end
  end

  assign sample_word = '{rsvd: 1'b0, cnt: sample_cnt, tag: `PA_SAMPLE_TAG,
                         ones: 3'b111, smp: sample_bit};

  pin_sequencer pin_sequencer_i (
    .clk         (clk),
    .reset       (reset),
    .time_now    (time_now),
    .command     (command),
    .start_time  (start_time),
    .end_time    (end_time),
    .nco_incr    (nco_incr),
    .sample_rate (sample_rate),
    .pin_in      (pin_in),
    .cmd_clear   (cmd_clear),
    .state       (state),
    .pin_out     (pin_out),
    .pin_oe      (pin_oe),
    .sample_bit  (sample_bit),
    .sample_cnt  (sample_cnt)
  );

endmodule

/* rtl/pin_sequencer.sv */
`timescale 1ns/10ps
`include "pin_array_consts.svh"

module pin_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  pin_array_pkg::time_t      time_now,
  input  pin_array_pkg::data_t      command,
  input  pin_array_pkg::time_t      start_time,
  input  pin_array_pkg::time_t      end_time,
  input  pin_array_pkg::phase_t     nco_incr,
  input  pin_array_pkg::rate_t      sample_rate,
  input  logic                      pin_in,
  output logic                      cmd_clear,
  output pin_array_pkg::seq_state_t state,
  output logic                      pin_out,
  output logic                      pin_oe,
  output logic                      sample_bit,
  output pin_array_pkg::scnt_t      sample_cnt
);
  import pin_array_pkg::*;

  seq_state_t state_next;
  phase_t     phase_acc;
  rate_t      div_cnt;
  logic       stop_cmd;
  logic       out_done;

  assign stop_cmd = (command == `PA_CMD_STOP);
  // Output jobs end on time or on stop, whichever comes first.
  assign out_done = stop_cmd || (time_now >= end_time);

  always_comb begin
    state_next = state;
    cmd_clear  = 1'b0;
    case (state)
      idle: begin
        if (time_now >= start_time) begin
          if (command == `PA_CMD_START_OUTPUT) begin
            state_next = run_nco;
            cmd_clear  = 1'b1;
          end else if (command == `PA_CMD_CONST) begin
            state_next = run_const;
            cmd_clear  = 1'b1;
          end else if (command == `PA_CMD_INPUT_STREAM) begin
            state_next = stream_in;
            cmd_clear  = 1'b1;
          end
        end
        // A stop with no job running is simply consumed.
        if (stop_cmd) begin
          cmd_clear = 1'b1;
        end
      end
      run_nco, run_const: begin
        if (out_done) begin
          state_next = idle;
        end
        cmd_clear = stop_cmd;
      end
      stream_in: begin
        if (stop_cmd) begin
          state_next = idle;
        end
        cmd_clear = stop_cmd;
      end
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= idle;
      phase_acc  <= '0;
      div_cnt    <= '0;
      sample_bit <= 1'b0;
      sample_cnt <= '0;
      pin_out    <= 1'b0;
      pin_oe     <= 1'b0;
    end else begin
      state <= state_next;
      // Pin drive follows the state with one cycle of lag.
      pin_oe  <= (state == run_nco) || (state == run_const);
      pin_out <= (state == run_const) || ((state == run_nco) && phase_acc[31]);
      if (state == run_nco) begin
        phase_acc <= phase_acc + nco_incr;
      end else begin
        phase_acc <= '0;
      end
      // Divider reloads on every sample, and holds the rate while not streaming.
      if (state == stream_in) begin
        if (div_cnt <= rate_t'(1)) begin
          div_cnt    <= sample_rate;
          sample_bit <= pin_in;
          sample_cnt <= sample_cnt + 1'b1;
        end else begin
          div_cnt <= div_cnt - 1'b1;
        end
      end else begin
        div_cnt <= sample_rate;
      end
    end
  end

endmodule

/* rtl/time_base.sv */
`timescale 1ns/10ps
`include "pin_array_consts.svh"

module time_base (
  input  logic                    clk,
  input  logic                    reset,
  input  pin_array_pkg::bus_req_t bus_req,
  output pin_array_pkg::time_t    time_now
);
  import pin_array_pkg::*;

  logic gcmd_wr;
  logic frozen;

  // Global command lives at channel 0, offset 0.
  assign gcmd_wr = bus_req.valid && bus_req.write &&
                   (bus_req.addr == {8'd0, `PA_REG_GLOBAL_CMD});

  always_ff @(posedge clk) begin
    if (reset) begin
      time_now <= '0;
      frozen   <= 1'b0;
    end else begin
      if (gcmd_wr && (bus_req.wdata == `PA_GCMD_CLEAR_TIME)) begin
        time_now <= '0;
      end else if (!frozen) begin
        time_now <= time_now + 1'b1;
      end
      // Clear leaves the run/freeze mode alone.
      if (gcmd_wr && (bus_req.wdata == `PA_GCMD_FREEZE)) begin
        frozen <= 1'b1;
      end else if (gcmd_wr && (bus_req.wdata == `PA_GCMD_RUN)) begin
        frozen <= 1'b0;
      end
    end
  end

endmodule

/* rtl/pin_array_pkg.sv */
`include "pin_array_consts.svh"

package pin_array_pkg;

  // Upper byte is the channel, lower byte the register offset.
  typedef logic [15:0] addr_t;
  typedef logic [15:0] data_t;
  typedef logic [31:0] time_t;
  typedef logic [31:0] phase_t;
  typedef logic [15:0] rate_t;
  typedef logic [14:0] scnt_t;
  typedef logic [`PA_CH_BITS-1:0] chan_t;

  // One access per cycle, no back-pressure.
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Sample word as seen on the readout port.
  // Top bit is spare and always zero.
  typedef struct packed {
    logic        rsvd;
    scnt_t       cnt;
    logic [11:0] tag;
    logic [2:0]  ones;
    logic        smp;
  } sample_word_t;

  typedef enum logic [1:0] {
    idle      = 2'd0,
    run_nco   = 2'd1,
    run_const = 2'd2,
    stream_in = 2'd3
  } seq_state_t;

endpackage

/* include/pin_array_consts.svh */
`ifndef PIN_ARRAY_CONSTS_SVH
`define PIN_ARRAY_CONSTS_SVH

// Array size and channel field width.
`define PA_NUM_CHANNELS 4
`define PA_CH_BITS 8

// Register byte offsets within one channel.
`define PA_REG_GLOBAL_CMD 8'd0
`define PA_REG_NCO_LOW 8'd2
`define PA_REG_NCO_HIGH 8'd3
`define PA_REG_LOCAL_CMD 8'd5
`define PA_REG_SAMPLE_RATE 8'd6
`define PA_REG_SAMPLE_REG 8'd7
`define PA_REG_SAMPLE_CNT 8'd8
`define PA_REG_STATUS 8'd9
`define PA_REG_LAST_DATA 8'd10
`define PA_REG_START_L 8'd11
`define PA_REG_START_H 8'd12
`define PA_REG_END_L 8'd13
`define PA_REG_END_H 8'd14

// Local command codes.
`define PA_CMD_START_OUTPUT 16'd1
`define PA_CMD_CONST 16'd2
`define PA_CMD_INPUT_STREAM 16'd3
`define PA_CMD_STOP 16'd5

// Global command codes, written to channel 0 offset 0.
`define PA_GCMD_CLEAR_TIME 16'd1
`define PA_GCMD_FREEZE 16'd2
`define PA_GCMD_RUN 16'd3

`define PA_SAMPLE_TAG 12'hABC

`endif
